// File: bench/decode_ref.svh
`ifndef DECODE_REF_SVH
`define DECODE_REF_SVH

// expected micro-op, straight from the rv32i field layout
function automatic decode_pkg::uop_t decode_ref(input logic [31:0] w,
	input decode_pkg::fetch_info_t f);
	decode_pkg::uop_t u;
	decode_pkg::uop_op_t op0;
	logic [decode_pkg::LG_PRF_ENTRIES-1:0] rs1_s;
	logic [decode_pkg::LG_PRF_ENTRIES-1:0] rs2_s;
	logic [decode_pkg::LG_PRF_ENTRIES-1:0] rd_s;
	logic [2:0] f3;
	logic [6:0] f7;
	logic rd_nz;
	logic ld;
	logic st;
	logic alu_i;
	logic alu_r;
	logic upper;
	logic bcond;
	logic jal;
	logic jalr;
	logic sys;
	f3 = w[14:12];
	f7 = w[31:25];
	rd_nz = (w[11:7] != 5'd0);
	rs1_s = '0;
	rs1_s[4:0] = w[19:15];
	rs2_s = '0;
	rs2_s[4:0] = w[24:20];
	rd_s = '0;
	rd_s[4:0] = w[11:7];
	// instruction class by major opcode
	ld = (w[6:0] == decode_pkg::OPC_LOAD);
	st = (w[6:0] == decode_pkg::OPC_STORE);
	alu_i = (w[6:0] == decode_pkg::OPC_OP_IMM);
	alu_r = (w[6:0] == decode_pkg::OPC_OP);
	upper = (w[6:0] == decode_pkg::OPC_LUI) || (w[6:0] == decode_pkg::OPC_AUIPC);
	bcond = (w[6:0] == decode_pkg::OPC_BRANCH);
	jal = (w[6:0] == decode_pkg::OPC_JAL);
	jalr = (w[6:0] == decode_pkg::OPC_JALR);
	sys = (w[6:0] == decode_pkg::OPC_SYSTEM);
	// supported encodings, everything else illegal
	op0 = decode_pkg::II;
	case (w[6:0])
		decode_pkg::OPC_LOAD:
			case (f3)
				3'd0: op0 = decode_pkg::LB;
				3'd1: op0 = decode_pkg::LH;
				3'd2: op0 = decode_pkg::LW;
				3'd4: op0 = decode_pkg::LBU;
				3'd5: op0 = decode_pkg::LHU;
				default: op0 = decode_pkg::II;
			endcase
		decode_pkg::OPC_OP_IMM:
			case (f3)
				3'd0: op0 = decode_pkg::ADDI;
				3'd1: op0 = decode_pkg::SLLI;
				3'd2: op0 = decode_pkg::SLTI;
				3'd4: op0 = decode_pkg::XORI;
				3'd5: op0 = (f7 == 7'h00) ? decode_pkg::SRLI :
					((f7 == decode_pkg::FUNCT7_ALT) ? decode_pkg::SRAI : decode_pkg::II);
				3'd6: op0 = decode_pkg::ORI;
				3'd7: op0 = decode_pkg::ANDI;
				default: op0 = decode_pkg::II;
			endcase
		decode_pkg::OPC_STORE:
			case (f3)
				3'd0: op0 = decode_pkg::SB;
				3'd1: op0 = decode_pkg::SH;
				3'd2: op0 = decode_pkg::SW;
				default: op0 = decode_pkg::II;
			endcase
		decode_pkg::OPC_OP:
			if (f7 == 7'h00)
			begin
				case (f3)
					3'd0: op0 = decode_pkg::ADDU;
					3'd1: op0 = decode_pkg::SLL;
					3'd3: op0 = decode_pkg::SLTU;
					3'd4: op0 = decode_pkg::XOR;
					3'd6: op0 = decode_pkg::OR;
					3'd7: op0 = decode_pkg::AND;
					default: op0 = decode_pkg::II;
				endcase
			end
			else if ((f7 == decode_pkg::FUNCT7_ALT) && (f3 == 3'd0))
				op0 = decode_pkg::SUBU;
		decode_pkg::OPC_BRANCH:
			case (f3)
				3'd0: op0 = decode_pkg::BEQ;
				3'd1: op0 = decode_pkg::BNE;
				3'd4: op0 = decode_pkg::BLT;
				3'd5: op0 = decode_pkg::BGE;
				3'd6: op0 = decode_pkg::BLTU;
				3'd7: op0 = decode_pkg::BGEU;
				default: op0 = decode_pkg::II;
			endcase
		decode_pkg::OPC_MISC_MEM: op0 = decode_pkg::NOP;
		decode_pkg::OPC_AUIPC: op0 = decode_pkg::AUIPC;
		decode_pkg::OPC_LUI: op0 = decode_pkg::LUI;
		decode_pkg::OPC_JALR: op0 = decode_pkg::JALR;
		decode_pkg::OPC_JAL: op0 = decode_pkg::JAL;
		decode_pkg::OPC_SYSTEM: op0 = (w[31:7] == 25'd0) ? decode_pkg::BREAK : decode_pkg::NOP;
		default: op0 = decode_pkg::II;
	endcase
	u = '0;
	u.pc = f.pc;
	u.pht_idx = f.pht_idx;
	u.pred_target = f.pred_target;
	// illegal carries only the fetch fields
	if (op0 == decode_pkg::II)
		return u;
	u.op = op0;
	if ((ld || alu_i || alu_r || upper) && !rd_nz)
		u.op = decode_pkg::NOP;
	if (jal && !rd_nz)
		u.op = decode_pkg::J;
	if (jalr && !rd_nz)
		u.op = decode_pkg::JR;
	// source operands
	if (ld || alu_i || alu_r || st || bcond || jalr)
		u.srcA = rs1_s;
	u.srcA_valid = (ld || alu_i) ? rd_nz : (alu_r || st || bcond || jalr);
	if (alu_r || st || bcond)
	begin
		u.srcB = rs2_s;
		u.srcB_valid = 1'b1;
	end
	if (ld || alu_i || alu_r || upper || jal || jalr)
	begin
		u.dst = rd_s;
		u.dst_valid = rd_nz;
	end
	// immediates per the isa spec bit maps
	if (ld || alu_i || jalr)
		u.rvimm = {{20{w[31]}}, w[31:20]};
	else if (st)
		u.rvimm = {{20{w[31]}}, w[31:25], w[11:7]};
	else if (bcond)
		u.rvimm = {{19{w[31]}}, w[31], w[7], w[30:25], w[11:8], 1'b0};
	else if (upper)
		u.rvimm = {w[31:12], 12'h000};
	else if (jal)
		u.rvimm = {{11{w[31]}}, w[31], w[19:12], w[20], w[30:21], 1'b0};
	u.is_mem = ld || st;
	u.is_store = st;
	u.is_int = alu_i || alu_r || upper || bcond || jal || jalr || sys;
	u.is_br = jal || jalr;
	u.br_pred = jal || jalr || (bcond && f.pred);
	u.serializing_op = (op0 == decode_pkg::BREAK);
	return u;
endfunction

// random word of one class, k steers rd, funct7 and system forms
function automatic logic [31:0] build_insn(input int cls, input logic [31:0] r,
	input logic [31:0] k);
	logic [31:0] w;
	w = r;
	case (cls)
		0: w[6:0] = decode_pkg::OPC_LOAD;
		1: w[6:0] = decode_pkg::OPC_MISC_MEM;
		2: w[6:0] = decode_pkg::OPC_OP_IMM;
		3: w[6:0] = decode_pkg::OPC_AUIPC;
		4: w[6:0] = decode_pkg::OPC_STORE;
		5: w[6:0] = decode_pkg::OPC_OP;
		6: w[6:0] = decode_pkg::OPC_LUI;
		7: w[6:0] = decode_pkg::OPC_BRANCH;
		8: w[6:0] = decode_pkg::OPC_JALR;
		9: w[6:0] = decode_pkg::OPC_JAL;
		10:
		begin
			w[6:0] = decode_pkg::OPC_SYSTEM;
			if (k[2])
				w[31:7] = '0;
		end
		// any opcode, mostly unused ones
		default: w[1:0] = 2'b11;
	endcase
	// mostly legal funct7 for reg ops and right shifts
	if ((cls == 5) || ((cls == 2) && (w[14:12] == 3'd5)))
		if (k[5:4] != 2'd3)
			w[31:25] = k[4] ? decode_pkg::FUNCT7_ALT : 7'h00;
	// a quarter write x0
	if (k[1:0] == 2'd0)
		w[11:7] = 5'd0;
	return w;
endfunction

`endif

// File: bench/tb_decode.sv
`timescale 1ns/1ps

module tb_decode;

	logic clk;
	logic rst_n;
	logic insn_valid;
	decode_pkg::rv_insn_t insn;
	decode_pkg::fetch_info_t fetch;
	logic uop_valid;
	decode_pkg::uop_t uop;

	// run length in stimulus cycles
	int num_idle = 4;
	int num_directed = 14;
	int num_random = 300;
	int num_gap = 200;

	integer seed = 32'h6d49_c48f;
	int checks = 0;
	int errors = 0;

	// model of the output latch
	logic exp_valid;
	decode_pkg::uop_t exp_uop;
	logic primed = 1'b0;
	decode_pkg::uop_t exp_q[$];
	logic [31:0] directed_words [14];

	`include "decode_ref.svh"

	rv_decode_stage UUT
	(
		.clk(clk),
		.rst_n(rst_n),
		.insn_valid(insn_valid),
		.insn(insn),
		.fetch(fetch),
		.uop_valid(uop_valid),
		.uop(uop)
	);

	always #20 clk = ~clk;

	task automatic check_field(input string name, input logic [31:0] e, input logic [31:0] a);
		checks++;
		assert (a === e)
		else
		begin
			errors++;
			$display("ERR %s expected %h got %h at %0t", name, e, a, $time);
		end
	endtask

	task automatic check_uop(input decode_pkg::uop_t e, input decode_pkg::uop_t a);
		check_field("uop.op", 32'(e.op), 32'(a.op));
		check_field("uop.srcA", 32'(e.srcA), 32'(a.srcA));
		check_field("uop.srcA_valid", 32'(e.srcA_valid), 32'(a.srcA_valid));
		check_field("uop.srcB", 32'(e.srcB), 32'(a.srcB));
		check_field("uop.srcB_valid", 32'(e.srcB_valid), 32'(a.srcB_valid));
		check_field("uop.dst", 32'(e.dst), 32'(a.dst));
		check_field("uop.dst_valid", 32'(e.dst_valid), 32'(a.dst_valid));
		check_field("uop.rvimm", e.rvimm, a.rvimm);
		check_field("uop.is_mem", 32'(e.is_mem), 32'(a.is_mem));
		check_field("uop.is_int", 32'(e.is_int), 32'(a.is_int));
		check_field("uop.is_store", 32'(e.is_store), 32'(a.is_store));
		check_field("uop.is_br", 32'(e.is_br), 32'(a.is_br));
		check_field("uop.br_pred", 32'(e.br_pred), 32'(a.br_pred));
		check_field("uop.serializing_op", 32'(e.serializing_op), 32'(a.serializing_op));
		check_field("uop.pc", e.pc, a.pc);
		check_field("uop.pht_idx", 32'(e.pht_idx), 32'(a.pht_idx));
		check_field("uop.pred_target", e.pred_target, a.pred_target);
	endtask

	// one falling-edge drive with fresh fetch data
	task automatic drive_cycle(input logic v, input logic [31:0] w);
		decode_pkg::fetch_info_t f;
		logic [31:0] r;
		@(negedge clk);
		r = $random(seed);
		f.pc = r;
		r = $random(seed);
		f.pred_target = r;
		r = $random(seed);
		f.pred = r[8];
		f.pht_idx = r[7:0];
		insn_valid = v;
		insn = w;
		fetch = f;
		if (v)
			exp_q.push_back(decode_ref(w, f));
	endtask

	// compare last edge's result, then load this edge's expectation
	always @(posedge clk)
	begin
		if (primed)
		begin
			check_field("uop_valid", 32'(exp_valid), 32'(uop_valid));
			check_uop(exp_uop, uop);
		end
		primed = 1'b1;
		if (!rst_n)
		begin
			exp_valid = 1'b0;
			exp_uop = '0;
		end
		else
		begin
			exp_valid = insn_valid;
			if (insn_valid)
				exp_uop = exp_q.pop_front();
		end
	end

	// limit derived from the stimulus length
	initial
	begin
		#((num_idle + num_directed + num_random + num_gap + 20) * 40);
		$display("watchdog expired before the stimulus and checks completed");
		$display("checks %0d, value errors %0d, timeouts 1", checks, errors);
		$display(">>> FAIL");
		$finish;
	end

	initial
	begin
		logic [31:0] r;
		logic [31:0] k;
		clk = 1'b0;
		rst_n = 1'b0;
		insn_valid = 1'b0;
		insn = '0;
		fetch = '0;
		exp_valid = 1'b0;
		exp_uop = '0;
		// x0 writers, illegal forms, system and fence
		directed_words = '{
			32'h0000_0013,
			32'h0000_2003,
			32'h1234_5037,
			32'h0000_0017,
			32'h0100_006f,
			32'h0000_8067,
			32'h0000_000b,
			32'h0010_b093,
			32'h0231_00b3,
			32'h0020_a0b3,
			32'h4031_00b3,
			32'h0000_0073,
			32'h0010_0073,
			32'h0ff0_000f
		};
		repeat (3) @(posedge clk);
		@(negedge clk);
		rst_n = 1'b1;
		// garbage words with no strobe must not reach uop
		repeat (num_idle) drive_cycle(1'b0, $random(seed));
		foreach (directed_words[i])
			drive_cycle(1'b1, directed_words[i]);
		// back to back
		for (int i = 0; i < num_random; i++)
		begin
			r = $random(seed);
			k = $random(seed);
			drive_cycle(1'b1, build_insn(32'(k[31:28]) % 12, r, k));
		end
		// strobe high about three cycles in four
		for (int i = 0; i < num_gap; i++)
		begin
			r = $random(seed);
			k = $random(seed);
			drive_cycle(k[8] | k[9], build_insn(32'(k[31:28]) % 12, r, k));
		end
		drive_cycle(1'b0, 32'h0);
		repeat (2) @(posedge clk);
		@(negedge clk);
		$display("checks %0d, value errors %0d", checks, errors);
		if (errors == 0)
			$display(">>> PASS");
		else
			$display(">>> FAIL");
		$finish;
	end

endmodule

// File: rtl/decode_pkg.sv
package decode_pkg;

	// datapath widths
	localparam int XLEN = 32;
	localparam int LG_PRF_ENTRIES = 6;
	localparam int LG_PHT_SZ = 8;

	// arch regs are 5 bits, padded up to the prf specifier width
	localparam int REG_PAD = LG_PRF_ENTRIES - 5;

	// rv32i major opcodes, insn[6:0]
	localparam logic [6:0] OPC_LOAD = 7'h03;
	localparam logic [6:0] OPC_MISC_MEM = 7'h0f;
	localparam logic [6:0] OPC_OP_IMM = 7'h13;
	localparam logic [6:0] OPC_AUIPC = 7'h17;
	localparam logic [6:0] OPC_STORE = 7'h23;
	localparam logic [6:0] OPC_OP = 7'h33;
	localparam logic [6:0] OPC_LUI = 7'h37;
	localparam logic [6:0] OPC_BRANCH = 7'h63;
	localparam logic [6:0] OPC_JALR = 7'h67;
	localparam logic [6:0] OPC_JAL = 7'h6f;
	localparam logic [6:0] OPC_SYSTEM = 7'h73;

	// funct7 values, base form and the sub / arithmetic shift form
	localparam logic [6:0] FUNCT7_BASE = 7'h00;
	localparam logic [6:0] FUNCT7_ALT = 7'h20;

	// micro-op codes
	// II must stay at zero, an all-zero uop reads as illegal
	typedef enum logic [5:0] {
		II,
		NOP,
		// loads
		LB, LH, LW, LBU, LHU,
		// stores
		SB, SH, SW,
		// reg-imm alu
		ADDI, SLLI, SLTI, XORI, SRLI, SRAI, ORI, ANDI,
		AUIPC,
		LUI,
		// reg-reg alu
		ADDU, SUBU, SLL, SLTU, XOR, OR, AND,
		// conditional branches
		BEQ, BNE, BLT, BGE, BLTU, BGEU,
		// unconditional jumps
		J, JAL, JR, JALR,
		BREAK
	} uop_op_t;

	// immediate layouts, FMT_NONE yields a zero immediate
	typedef enum logic [2:0] {
		FMT_NONE,
		FMT_I,
		FMT_S,
		FMT_B,
		FMT_U,
		FMT_J
	} imm_fmt_t;

	// register-register layout
	typedef struct packed {
		logic [6:0] funct7;
		logic [4:0] rs2;
		logic [4:0] rs1;
		logic [2:0] funct3;
		logic [4:0] rd;
		logic [6:0] opcode;
	} rv_r_t;

	// immediate, loads and jalr
	typedef struct packed {
		logic [11:0] imm12;
		logic [4:0] rs1;
		logic [2:0] funct3;
		logic [4:0] rd;
		logic [6:0] opcode;
	} rv_i_t;

	// stores, branches reuse the same split
	typedef struct packed {
		logic [6:0] imm_hi;
		logic [4:0] rs2;
		logic [4:0] rs1;
		logic [2:0] funct3;
		logic [4:0] imm_lo;
		logic [6:0] opcode;
	} rv_s_t;

	// lui / auipc, jal scrambles the same 20 bits
	typedef struct packed {
		logic [19:0] imm20;
		logic [4:0] rd;
		logic [6:0] opcode;
	} rv_u_t;

	// one fetched word, seen through each format
	typedef union packed {
		rv_r_t r;
		rv_i_t i;
		rv_s_t s;
		rv_u_t u;
	} rv_insn_t;

	// prediction state that rides along with the word from fetch
	typedef struct packed {
		logic [XLEN-1:0] pc;
		logic pred;
		logic [LG_PHT_SZ-1:0] pht_idx;
		logic [XLEN-1:0] pred_target;
	} fetch_info_t;

	// decoded micro-op handed to rename
	typedef struct packed {
		uop_op_t op;
		logic [LG_PRF_ENTRIES-1:0] srcA;
		logic srcA_valid;
		logic [LG_PRF_ENTRIES-1:0] srcB;
		logic srcB_valid;
		logic [LG_PRF_ENTRIES-1:0] dst;
		logic dst_valid;
		logic [XLEN-1:0] rvimm;
		logic is_mem;
		logic is_int;
		logic is_store;
		logic is_br;
		logic br_pred;
		logic serializing_op;
		logic [XLEN-1:0] pc;
		logic [LG_PHT_SZ-1:0] pht_idx;
		logic [XLEN-1:0] pred_target;
	} uop_t;

endpackage

// File: rtl/rv_decode_stage.sv
`timescale 1ns/1ps

module rv_decode_stage
(
	input logic clk,
	input logic rst_n,
	input logic insn_valid,
	input decode_pkg::rv_insn_t insn,
	input decode_pkg::fetch_info_t fetch,
	output logic uop_valid,
	output decode_pkg::uop_t uop
);

	decode_pkg::uop_op_t op;
	decode_pkg::imm_fmt_t imm_fmt;
	logic [decode_pkg::LG_PRF_ENTRIES-1:0] srcA;
	logic [decode_pkg::LG_PRF_ENTRIES-1:0] srcB;
	logic [decode_pkg::LG_PRF_ENTRIES-1:0] dst;
	logic srcA_valid;
	logic srcB_valid;
	logic dst_valid;
	logic is_mem;
	logic is_int;
	logic is_store;
	logic is_br;
	logic is_br_cond;
	logic serializing_op;
	logic [decode_pkg::XLEN-1:0] rvimm;
	decode_pkg::uop_t uop_nxt;

	// opcode / funct decode
	rv_op_decode u_op_decode
	(
		.insn(insn),
		.op(op),
		.srcA(srcA),
		.srcB(srcB),
		.dst(dst),
		.srcA_valid(srcA_valid),
		.srcB_valid(srcB_valid),
		.dst_valid(dst_valid),
		.is_mem(is_mem),
		.is_int(is_int),
		.is_store(is_store),
		.is_br(is_br),
		.is_br_cond(is_br_cond),
		.serializing_op(serializing_op),
		.imm_fmt(imm_fmt)
	);

	// immediate for whatever format the decoder picked
	rv_imm_gen u_imm_gen
	(
		.insn(insn),
		.fmt(imm_fmt),
		.rvimm(rvimm)
	);

	always_comb
	begin
		uop_nxt.op = op;
		uop_nxt.srcA = srcA;
		uop_nxt.srcA_valid = srcA_valid;
		uop_nxt.srcB = srcB;
		uop_nxt.srcB_valid = srcB_valid;
		uop_nxt.dst = dst;
		uop_nxt.dst_valid = dst_valid;
		uop_nxt.rvimm = rvimm;
		uop_nxt.is_mem = is_mem;
		uop_nxt.is_int = is_int;
		uop_nxt.is_store = is_store;
		uop_nxt.is_br = is_br;
		// jumps always taken, cond branches keep the fetch guess
		uop_nxt.br_pred = is_br | (is_br_cond & fetch.pred);
		uop_nxt.serializing_op = serializing_op;
		// prediction bookkeeping goes through untouched
		uop_nxt.pc = fetch.pc;
		uop_nxt.pht_idx = fetch.pht_idx;
		uop_nxt.pred_target = fetch.pred_target;
	end

	// decode/rename boundary, uop held while no new word arrives
	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			uop_valid <= 1'b0;
			uop <= '0;
		end
		else
		begin
			uop_valid <= insn_valid;
			if (insn_valid)
				uop <= uop_nxt;
		end
	end

endmodule

// File: rtl/rv_imm_gen.sv
`timescale 1ns/1ps

module rv_imm_gen
(
	input decode_pkg::rv_insn_t insn,
	input decode_pkg::imm_fmt_t fmt,
	output logic [decode_pkg::XLEN-1:0] rvimm
);

	logic [decode_pkg::XLEN-1:0] imm_i;
	logic [decode_pkg::XLEN-1:0] imm_s;
	logic [decode_pkg::XLEN-1:0] imm_b;
	logic [decode_pkg::XLEN-1:0] imm_u;
	logic [decode_pkg::XLEN-1:0] imm_j;
	logic sign;

	// sign bit is insn[31] in every format
	assign sign = insn.i.imm12[11];

	// loads, op-imm, jalr
	assign imm_i = {{(decode_pkg::XLEN-12){sign}}, insn.i.imm12};

	// stores, imm split around rs1/rs2
	assign imm_s = {{(decode_pkg::XLEN-12){sign}}, insn.s.imm_hi, insn.s.imm_lo};

	// branches, same split as stores but bit 11 moved down to insn[7]
	// offset is in halfwords so bit 0 stays clear
	assign imm_b = {{(decode_pkg::XLEN-12){sign}},
		insn.s.imm_lo[0],
		insn.s.imm_hi[5:0],
		insn.s.imm_lo[4:1],
		1'b0};

	// upper 20 bits, low 12 zero
	assign imm_u = {insn.u.imm20, 12'd0};

	// jal, imm20 holds {20, 10:1, 11, 19:12}
	assign imm_j = {{(decode_pkg::XLEN-20){sign}},
		insn.u.imm20[7:0],
		insn.u.imm20[8],
		insn.u.imm20[18:9],
		1'b0};

	always_comb
	begin
		case (fmt)
			decode_pkg::FMT_I: rvimm = imm_i;
			decode_pkg::FMT_S: rvimm = imm_s;
			decode_pkg::FMT_B: rvimm = imm_b;
			decode_pkg::FMT_U: rvimm = imm_u;
			decode_pkg::FMT_J: rvimm = imm_j;
			// register ops, fence, system
			default: rvimm = '0;
		endcase
	end

endmodule

// File: rtl/rv_op_decode.sv
`timescale 1ns/1ps

module rv_op_decode
(
	input decode_pkg::rv_insn_t insn,
	output decode_pkg::uop_op_t op,
	output logic [decode_pkg::LG_PRF_ENTRIES-1:0] srcA,
	output logic [decode_pkg::LG_PRF_ENTRIES-1:0] srcB,
	output logic [decode_pkg::LG_PRF_ENTRIES-1:0] dst,
	output logic srcA_valid,
	output logic srcB_valid,
	output logic dst_valid,
	output logic is_mem,
	output logic is_int,
	output logic is_store,
	output logic is_br,
	output logic is_br_cond,
	output logic serializing_op,
	output decode_pkg::imm_fmt_t imm_fmt
);

	// everything the decoder produces, cleared as one word
	typedef struct packed {
		decode_pkg::uop_op_t op;
		logic [decode_pkg::LG_PRF_ENTRIES-1:0] srcA;
		logic [decode_pkg::LG_PRF_ENTRIES-1:0] srcB;
		logic [decode_pkg::LG_PRF_ENTRIES-1:0] dst;
		logic srcA_valid;
		logic srcB_valid;
		logic dst_valid;
		logic is_mem;
		logic is_int;
		logic is_store;
		logic is_br;
		logic is_br_cond;
		logic serializing_op;
		decode_pkg::imm_fmt_t imm_fmt;
	} dec_t;

	dec_t d;

	logic [6:0] opcode;
	logic [2:0] funct3;
	logic [6:0] funct7;
	logic [decode_pkg::LG_PRF_ENTRIES-1:0] rd;
	logic [decode_pkg::LG_PRF_ENTRIES-1:0] rs1;
	logic [decode_pkg::LG_PRF_ENTRIES-1:0] rs2;
	logic rd_nz;
	logic sys_upper_zero;

	// field pickoff, r view covers opcode/funct/regs
	assign opcode = insn.r.opcode;
	assign funct3 = insn.r.funct3;
	assign funct7 = insn.r.funct7;
	assign rd = {{decode_pkg::REG_PAD{1'b0}}, insn.r.rd};
	assign rs1 = {{decode_pkg::REG_PAD{1'b0}}, insn.r.rs1};
	assign rs2 = {{decode_pkg::REG_PAD{1'b0}}, insn.r.rs2};
	assign rd_nz = (insn.r.rd != 5'd0);

	// ebreak/ecall style word with nothing above the opcode
	assign sys_upper_zero = ({insn.u.imm20, insn.u.rd} == 25'd0);

	// writes to x0 have no effect, fold to nop
	function automatic decode_pkg::uop_op_t wr_op(input decode_pkg::uop_op_t o, input logic nz);
		wr_op = nz ? o : decode_pkg::NOP;
	endfunction

	always_comb
	begin
		d = '0;
		case (opcode)
			decode_pkg::OPC_LOAD:
			begin
				d.dst = rd;
				d.srcA = rs1;
				d.dst_valid = rd_nz;
				// base reg only read if the load survives folding
				d.srcA_valid = rd_nz;
				d.is_mem = 1'b1;
				d.imm_fmt = decode_pkg::FMT_I;
				case (funct3)
					3'd0: d.op = wr_op(decode_pkg::LB, rd_nz);
					3'd1: d.op = wr_op(decode_pkg::LH, rd_nz);
					3'd2: d.op = wr_op(decode_pkg::LW, rd_nz);
					3'd4: d.op = wr_op(decode_pkg::LBU, rd_nz);
					3'd5: d.op = wr_op(decode_pkg::LHU, rd_nz);
					default: d.op = decode_pkg::II;
				endcase
			end
			// fence, nothing to order in this core
			decode_pkg::OPC_MISC_MEM:
			begin
				d.op = decode_pkg::NOP;
			end
			decode_pkg::OPC_OP_IMM:
			begin
				d.dst = rd;
				d.srcA = rs1;
				d.dst_valid = rd_nz;
				d.srcA_valid = rd_nz;
				d.is_int = 1'b1;
				d.imm_fmt = decode_pkg::FMT_I;
				case (funct3)
					3'd0: d.op = wr_op(decode_pkg::ADDI, rd_nz);
					3'd1: d.op = wr_op(decode_pkg::SLLI, rd_nz);
					3'd2: d.op = wr_op(decode_pkg::SLTI, rd_nz);
					3'd4: d.op = wr_op(decode_pkg::XORI, rd_nz);
					3'd5:
					begin
						// shift type lives in the top imm bits
						if (funct7 == decode_pkg::FUNCT7_BASE)
							d.op = wr_op(decode_pkg::SRLI, rd_nz);
						else if (funct7 == decode_pkg::FUNCT7_ALT)
							d.op = wr_op(decode_pkg::SRAI, rd_nz);
					end
					3'd6: d.op = wr_op(decode_pkg::ORI, rd_nz);
					3'd7: d.op = wr_op(decode_pkg::ANDI, rd_nz);
					// sltiu not supported
					default: d.op = decode_pkg::II;
				endcase
			end
			decode_pkg::OPC_AUIPC:
			begin
				d.op = wr_op(decode_pkg::AUIPC, rd_nz);
				d.dst = rd;
				d.dst_valid = rd_nz;
				d.is_int = 1'b1;
				d.imm_fmt = decode_pkg::FMT_U;
			end
			decode_pkg::OPC_STORE:
			begin
				d.srcA = rs1;
				d.srcB = rs2;
				d.srcA_valid = 1'b1;
				d.srcB_valid = 1'b1;
				d.is_mem = 1'b1;
				d.is_store = 1'b1;
				d.imm_fmt = decode_pkg::FMT_S;
				case (funct3)
					3'd0: d.op = decode_pkg::SB;
					3'd1: d.op = decode_pkg::SH;
					3'd2: d.op = decode_pkg::SW;
					default: d.op = decode_pkg::II;
				endcase
			end
			decode_pkg::OPC_OP:
			begin
				d.dst = rd;
				d.dst_valid = rd_nz;
				d.srcA = rs1;
				d.srcB = rs2;
				d.srcA_valid = 1'b1;
				d.srcB_valid = 1'b1;
				d.is_int = 1'b1;
				// only funct7 zero accepted, except sub
				if (funct7 == decode_pkg::FUNCT7_BASE)
				begin
					case (funct3)
						3'd0: d.op = wr_op(decode_pkg::ADDU, rd_nz);
						3'd1: d.op = wr_op(decode_pkg::SLL, rd_nz);
						3'd3: d.op = wr_op(decode_pkg::SLTU, rd_nz);
						3'd4: d.op = wr_op(decode_pkg::XOR, rd_nz);
						3'd6: d.op = wr_op(decode_pkg::OR, rd_nz);
						3'd7: d.op = wr_op(decode_pkg::AND, rd_nz);
						// slt, srl still missing
						default: d.op = decode_pkg::II;
					endcase
				end
				else if ((funct7 == decode_pkg::FUNCT7_ALT) && (funct3 == 3'd0))
					d.op = wr_op(decode_pkg::SUBU, rd_nz);
			end
			decode_pkg::OPC_LUI:
			begin
				d.op = wr_op(decode_pkg::LUI, rd_nz);
				d.dst = rd;
				d.dst_valid = rd_nz;
				d.is_int = 1'b1;
				d.imm_fmt = decode_pkg::FMT_U;
			end
			decode_pkg::OPC_BRANCH:
			begin
				d.srcA = rs1;
				d.srcB = rs2;
				d.srcA_valid = 1'b1;
				d.srcB_valid = 1'b1;
				d.is_int = 1'b1;
				d.is_br_cond = 1'b1;
				d.imm_fmt = decode_pkg::FMT_B;
				case (funct3)
					3'd0: d.op = decode_pkg::BEQ;
					3'd1: d.op = decode_pkg::BNE;
					3'd4: d.op = decode_pkg::BLT;
					3'd5: d.op = decode_pkg::BGE;
					3'd6: d.op = decode_pkg::BLTU;
					3'd7: d.op = decode_pkg::BGEU;
					default: d.op = decode_pkg::II;
				endcase
			end
			// jalr, rd = x0 is a plain indirect jump
			decode_pkg::OPC_JALR:
			begin
				d.srcA = rs1;
				d.srcA_valid = 1'b1;
				d.is_int = 1'b1;
				d.is_br = 1'b1;
				d.imm_fmt = decode_pkg::FMT_I;
				d.op = rd_nz ? decode_pkg::JALR : decode_pkg::JR;
				d.dst = rd;
				d.dst_valid = rd_nz;
			end
			decode_pkg::OPC_JAL:
			begin
				d.is_int = 1'b1;
				d.is_br = 1'b1;
				d.imm_fmt = decode_pkg::FMT_J;
				d.op = rd_nz ? decode_pkg::JAL : decode_pkg::J;
				d.dst = rd;
				d.dst_valid = rd_nz;
			end
			// system space, only the all-zero word matters here
			decode_pkg::OPC_SYSTEM:
			begin
				d.is_int = 1'b1;
				if (sys_upper_zero)
				begin
					d.op = decode_pkg::BREAK;
					d.serializing_op = 1'b1;
				end
				else
					d.op = decode_pkg::NOP;
			end
			default: d.op = decode_pkg::II;
		endcase

		// illegal words carry no operands and no class
		if (d.op == decode_pkg::II)
			d = '0;
	end

	assign op = d.op;
	assign srcA = d.srcA;
	assign srcB = d.srcB;
	assign dst = d.dst;
	assign srcA_valid = d.srcA_valid;
	assign srcB_valid = d.srcB_valid;
	assign dst_valid = d.dst_valid;
	assign is_mem = d.is_mem;
	assign is_int = d.is_int;
	assign is_store = d.is_store;
	assign is_br = d.is_br;
	assign is_br_cond = d.is_br_cond;
	assign serializing_op = d.serializing_op;
	assign imm_fmt = d.imm_fmt;

endmodule

// File: run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --assert --timescale 1ns/1ps --top-module tb_decode -f sources.f
out=$(./obj_dir/Vtb_decode)
printf '%s\n' "$out"
if printf '%s\n' "$out" | grep -qx '>>> PASS'
then
	exit 0
fi
exit 1

// File: sources.f
+incdir+bench
rtl/decode_pkg.sv
rtl/rv_op_decode.sv
rtl/rv_imm_gen.sv
rtl/rv_decode_stage.sv
bench/tb_decode.sv
